// ==== build.f ====
verilog/fdc_regs_pkg.sv
verilog/fdc_timing_pkg.sv
verilog/host_regs.sv
verilog/index_timer.sv
verilog/step_controller.sv
verilog/fdc_top.sv
tb/fdc_props.sv
tb/fdc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the floppy controller testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert -Wno-fatal --top-module fdc_tb -f build.f --Mdir obj_dir
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

./obj_dir/Vfdc_tb > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q "Errors found" "$log"; then
	exit 1
fi
exit 0

// ==== tb/fdc_tb.sv ====
`timescale 1ns/1ns

module fdc_tb;

	typedef enum {K_READ, K_READ_IDLE, K_DRIVE_LINES, K_DRIVE, K_SCRATCH, K_INDEX,
		K_SEEK_OUT, K_SEEK_HOME} kind_e;

	typedef struct {
		string       name;
		kind_e       kind;
		logic [7:0]  addr;	// Register, or step rate for seeks
		int          value;	// Write data, index period or step count
		logic [15:0] exp_val;
	} test_t;

	logic                    CLK_MASTER = 1'b0;
	logic                    rst;
	fdc_regs_pkg::mcu_bus_t  mcu;
	fdc_timing_pkg::fd_in_t  fd_in;
	logic [7:0]              pmd_out;
	fdc_timing_pkg::fd_out_t fd_out;

	test_t       tests[$];
	int          errors = 0;
	int          checks = 0;
	int          budget = 0;	// Watchdog length in cycles
	logic [31:0] rng_state = 32'h78b9;

	// Step pulse monitor state
	int   fall_count = 0;
	int   low_len = 0;
	int   low_bad = 0;
	int   dir_bad = 0;
	int   exp_low = 0;
	logic exp_dir = 1'b1;
	logic step_prev = 1'b1;

	fdc_top u_fdc_top (
		.CLK_MASTER (CLK_MASTER),
		.rst        (rst),
		.mcu        (mcu),
		.fd_in      (fd_in),
		.pmd_out    (pmd_out),
		.fd_out     (fd_out)
	);

	always #20 CLK_MASTER = ~CLK_MASTER;	// 40 ns period

	//////////////////////////////
	// Helpers

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic fdc_regs_pkg::mcu_bus_t bus_word(input logic [7:0] d,
		input logic ale, input logic rd, input logic wr);
		fdc_regs_pkg::mcu_bus_t b;
		b.data = d;
		b.ale  = ale;
		b.rd   = rd;
		b.wr   = wr;
		return b;
	endfunction

	// Drive lines back in register bit order
	function automatic logic [7:0] drive_lines();
		return {fd_out.side, fd_out.motor, fd_out.drv_sel, fd_out.in_use, fd_out.density};
	endfunction

	function automatic int entry_cycles(input test_t t);
		int phase;
		phase = (int'(t.addr) + 1) * fdc_timing_pkg::STEP_TICK_CYCLES;
		case (t.kind)
			K_INDEX:     return 2 * t.value + 100;
			K_SEEK_OUT:  return t.value * 2 * phase + 200;
			K_SEEK_HOME: return (t.value + 1) * 2 * phase + 400;	// Plus the outward step
			default:     return 40;
		endcase
	endfunction

	task automatic add_test(input string name, input kind_e kind, input logic [7:0] addr,
		input int value, input logic [15:0] exp_val);
		test_t t;
		t.name    = name;
		t.kind    = kind;
		t.addr    = addr;
		t.value   = value;
		t.exp_val = exp_val;
		tests.push_back(t);
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s: expected %02h, actual %02h", name, exp, act);
		end
	endtask

	//////////////////////////////
	// Bus tasks

	task automatic load_addr(input logic [7:0] a);
		@(posedge CLK_MASTER);
		mcu <= bus_word(a, 1'b1, 1'b0, 1'b0);
	endtask

	task automatic write_reg(input logic [7:0] a, input logic [7:0] d);
		load_addr(a);
		@(posedge CLK_MASTER);
		mcu <= bus_word(d, 1'b0, 1'b0, 1'b1);
		@(posedge CLK_MASTER);
		mcu <= bus_word(8'h00, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic read_reg(input logic [7:0] a, input logic rd_level, output logic [7:0] d);
		load_addr(a);
		@(posedge CLK_MASTER);
		mcu <= bus_word(8'h00, 1'b0, rd_level, 1'b0);
		@(negedge CLK_MASTER);
		d = pmd_out;	// Settled mid cycle
		@(posedge CLK_MASTER);
		mcu <= bus_word(8'h00, 1'b0, 1'b0, 1'b0);
	endtask

	//////////////////////////////
	// Index and step helpers

	// Two rising edges exactly period cycles apart
	task automatic index_pulses(input int period);
		@(posedge CLK_MASTER);
		for (int i = 0; i < 2; i++) begin
			fd_in.index <= 1'b1;
			repeat (10) @(posedge CLK_MASTER);
			fd_in.index <= 1'b0;
			repeat (period - 10) @(posedge CLK_MASTER);
		end
		repeat (5) @(posedge CLK_MASTER);	// Through the synchronizer
	endtask

	// Counts falling step_n edges and low phase lengths
	always @(negedge CLK_MASTER) begin
		if (!fd_out.step_n) begin
			if (step_prev) begin
				fall_count = fall_count + 1;
				low_len = 0;
			end
			low_len = low_len + 1;
			if (fd_out.dir !== exp_dir)
				dir_bad = dir_bad + 1;
		end else if (!step_prev && low_len != exp_low) begin
			low_bad = low_bad + 1;
		end
		step_prev = fd_out.step_n;
	end

	task automatic arm_step_monitor(input logic [7:0] rate, input logic dir);
		exp_low    = (int'(rate) + 1) * fdc_timing_pkg::STEP_TICK_CYCLES;
		exp_dir    = dir;
		fall_count = 0;
		low_bad    = 0;
		dir_bad    = 0;
	endtask

	task automatic wait_seek_done(input string name, input int max_polls);
		logic [7:0] d;
		int         polls;
		polls = 0;
		d = 8'h04;
		while (d[2] && polls < max_polls) begin
			read_reg(fdc_regs_pkg::REG_STATUS2, 1'b1, d);	// Busy bit
			polls++;
		end
		if (d[2]) begin
			errors++;
			$display("%s: seek still busy after %0d status polls", name, polls);
		end
	endtask

	task automatic check_pulse_shape(input string name);
		checks++;
		if (low_bad != 0 || dir_bad != 0) begin
			errors++;
			$display("%s: %0d step pulses had the wrong low length, %0d had the wrong dir",
				name, low_bad, dir_bad);
		end
	endtask

	//////////////////////////////
	// Per kind handlers

	task automatic apply_index(input test_t t);
		logic [7:0]  d;
		logic [15:0] exp;
		exp = 16'(t.value / fdc_timing_pkg::INDEX_TICK_CYCLES);	// Whole ticks only
		index_pulses(t.value);
		read_reg(fdc_regs_pkg::REG_STATUS1, 1'b1, d);
		check_byte({t.name, " new before"}, 8'h08, d & 8'h08);
		read_reg(fdc_regs_pkg::REG_INDEX_HI, 1'b1, d);
		check_byte({t.name, " hi"}, exp[15:8], d);
		read_reg(fdc_regs_pkg::REG_INDEX_LO, 1'b1, d);
		check_byte({t.name, " lo"}, exp[7:0], d);
		read_reg(fdc_regs_pkg::REG_STATUS1, 1'b1, d);
		check_byte({t.name, " new after"}, 8'h00, d & 8'h08);
	endtask

	task automatic apply_seek_out(input test_t t);
		logic [7:0] d;
		arm_step_monitor(t.addr, 1'b1);
		write_reg(fdc_regs_pkg::REG_STEP_RATE, t.addr);
		write_reg(fdc_regs_pkg::REG_STEP_CMD, {1'b1, 7'(t.value)});
		read_reg(fdc_regs_pkg::REG_STATUS2, 1'b1, d);
		check_byte({t.name, " busy"}, 8'h04, d & 8'h04);
		wait_seek_done(t.name, entry_cycles(t) / 3);
		check_byte({t.name, " pulses"}, 8'(t.value), 8'(fall_count));
		check_byte({t.name, " dir"}, 8'h01, {7'd0, fd_out.dir});
		check_pulse_shape(t.name);
	endtask

	task automatic apply_seek_home(input test_t t);
		logic [7:0] d;
		int         waited;
		waited = 0;
		arm_step_monitor(t.addr, 1'b0);
		write_reg(fdc_regs_pkg::REG_STEP_RATE, t.addr);
		write_reg(fdc_regs_pkg::REG_STEP_CMD, {1'b0, 7'(t.value)});
		while (fall_count < int'(t.exp_val) && waited < entry_cycles(t)) begin
			@(posedge CLK_MASTER);
			waited++;
		end
		fd_in.track0 <= 1'b1;	// Head reaches track 0 during step K
		wait_seek_done(t.name, entry_cycles(t) / 3);
		check_byte({t.name, " pulses"}, t.exp_val[7:0], 8'(fall_count));
		check_pulse_shape(t.name);
		read_reg(fdc_regs_pkg::REG_STATUS1, 1'b1, d);
		check_byte({t.name, " t0 hit"}, 8'h10, d & 8'h10);
		// One step back out clears the sticky bit
		@(posedge CLK_MASTER);
		fd_in.track0 <= 1'b0;
		arm_step_monitor(t.addr, 1'b1);
		write_reg(fdc_regs_pkg::REG_STEP_CMD, 8'h81);
		read_reg(fdc_regs_pkg::REG_STATUS1, 1'b1, d);
		check_byte({t.name, " t0 cleared"}, 8'h00, d & 8'h10);
		wait_seek_done(t.name, entry_cycles(t) / 3);
		check_byte({t.name, " out pulse"}, 8'h01, 8'(fall_count));
	endtask

	task automatic apply_test(input test_t t);
		logic [7:0] d;
		logic [7:0] r;
		case (t.kind)
			K_READ: begin
				read_reg(t.addr, 1'b1, d);
				check_byte(t.name, t.exp_val[7:0], d);
			end
			K_READ_IDLE: begin
				read_reg(t.addr, 1'b0, d);	// Read level held low
				check_byte(t.name, t.exp_val[7:0], d);
			end
			K_DRIVE_LINES: begin
				@(negedge CLK_MASTER);
				check_byte(t.name, t.exp_val[7:0], drive_lines());
			end
			K_DRIVE: begin
				write_reg(fdc_regs_pkg::REG_DRIVE_CTRL, 8'(t.value));
				@(negedge CLK_MASTER);
				check_byte(t.name, ~8'(t.value), drive_lines());	// Active low
			end
			K_SCRATCH: begin
				rng_state = xorshift32(rng_state);
				r = rng_state[7:0];
				write_reg(fdc_regs_pkg::REG_SCRATCH, r);
				read_reg(fdc_regs_pkg::REG_SCRATCH, 1'b1, d);
				check_byte(t.name, r, d);
				read_reg(fdc_regs_pkg::REG_SCRATCH_INV, 1'b1, d);
				check_byte({t.name, " inv"}, ~r, d);
			end
			K_INDEX:     apply_index(t);
			K_SEEK_OUT:  apply_seek_out(t);
			K_SEEK_HOME: apply_seek_home(t);
			default: ;
		endcase
	endtask

	//////////////////////////////
	// Stimulus table

	task automatic build_table();
		add_test("id_type_lo", K_READ, 8'h04, 0, {8'h00, fdc_regs_pkg::MCO_TYPE[7:0]});
		add_test("id_type_hi", K_READ, 8'h05, 0, {8'h00, fdc_regs_pkg::MCO_TYPE[15:8]});
		add_test("id_ver_lo", K_READ, 8'h06, 0, {8'h00, fdc_regs_pkg::MCO_VERSION[7:0]});
		add_test("id_ver_hi", K_READ, 8'h07, 0, {8'h00, fdc_regs_pkg::MCO_VERSION[15:8]});
		add_test("fixed_55", K_READ, 8'h32, 0, 16'h0055);
		add_test("fixed_aa", K_READ, 8'h33, 0, 16'h00AA);
		add_test("status1_reset", K_READ, 8'h0E, 0, 16'h0000);
		add_test("status2_idle", K_READ, 8'h0F, 0, 16'h0028);	// wrprot and density high
		add_test("read_level_low", K_READ_IDLE, 8'h32, 0, 16'h0000);
		add_test("drive_reset", K_DRIVE_LINES, 8'h00, 0, 16'h00FF);
		add_test("scratch_a", K_SCRATCH, 8'h30, 0, 16'h0000);
		add_test("scratch_b", K_SCRATCH, 8'h30, 0, 16'h0000);
		add_test("scratch_c", K_SCRATCH, 8'h30, 0, 16'h0000);
		add_test("drive_a5", K_DRIVE, 8'h04, 8'hA5, 16'h0000);
		add_test("drive_3c", K_DRIVE, 8'h04, 8'h3C, 16'h0000);
		add_test("drive_off", K_DRIVE, 8'h04, 8'h00, 16'h0000);
		add_test("index_250", K_INDEX, 8'h40, 250, 16'h0000);
		add_test("index_1099", K_INDEX, 8'h40, 1099, 16'h0000);
		add_test("index_25750", K_INDEX, 8'h40, 25750, 16'h0000);	// Both bytes nonzero
		add_test("seek_out_r0_n3", K_SEEK_OUT, 8'd0, 3, 16'h0000);
		add_test("seek_out_r2_n5", K_SEEK_OUT, 8'd2, 5, 16'h0000);
		add_test("seek_home_r1_n6", K_SEEK_HOME, 8'd1, 6, 16'd3);	// Track 0 after 3 steps
	endtask

	//////////////////////////////
	// Main and watchdog

	initial begin
		rst   = 1'b1;
		mcu   = bus_word(8'h00, 1'b0, 1'b0, 1'b0);
		fd_in = '{index: 1'b0, track0: 1'b0, wrprot: 1'b1, rdy_dchg: 1'b0, density: 1'b1};
		build_table();
		budget = 1000;	// Reset plus margin
		foreach (tests[i])
			budget = budget + entry_cycles(tests[i]);
		repeat (10) @(posedge CLK_MASTER);
		rst <= 1'b0;
		foreach (tests[i])
			apply_test(tests[i]);
		repeat (5) @(posedge CLK_MASTER);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	initial begin
		wait (budget > 0);
		repeat (budget) @(posedge CLK_MASTER);
		$display("Watchdog expired after %0d cycles, tests did not complete", budget);
		$display("Errors found");
		$finish;
	end

endmodule

// ==== tb/fdc_props.sv ====
`timescale 1ns/1ns

module fdc_props (
	input logic CLK_MASTER,
	input logic rst,
	input logic stepping,
	input logic dir,
	input logic step_n
);

	// Step pulse only inside a seek
	a_step_in_seek: assert property (@(posedge CLK_MASTER) disable iff (rst)
		!step_n |-> stepping) else $error("step_n low while not stepping");

	// Direction latched for the whole seek
	a_dir_stable: assert property (@(posedge CLK_MASTER) disable iff (rst)
		(stepping && $past(stepping)) |-> (dir == $past(dir)))
		else $error("dir changed during a seek");

	// Idle right out of reset
	a_idle_after_rst: assert property (@(posedge CLK_MASTER)
		rst |=> !stepping) else $error("stepping set in the cycle after reset");

endmodule

bind step_controller fdc_props u_fdc_props (
	.CLK_MASTER (CLK_MASTER),
	.rst        (rst),
	.stepping   (stepping),
	.dir        (dir),
	.step_n     (step_n)
);

// ==== verilog/fdc_top.sv ====
`timescale 1ns/1ns

module fdc_top (
	input  logic                   CLK_MASTER,
	input  logic                   rst,
	input  fdc_regs_pkg::mcu_bus_t mcu,
	input  fdc_timing_pkg::fd_in_t fd_in,
	output logic [7:0]             pmd_out,
	output fdc_timing_pkg::fd_out_t fd_out
);

	fdc_regs_pkg::drive_ctrl_t          drive_ctrl;
	logic [7:0]                         step_rate;
	fdc_regs_pkg::step_cmd_t            step_cmd;
	logic                               step_cmd_wr;
	logic                               index_hi_rd;
	logic                               stepping;
	logic                               track0_hit;
	logic                               dir;
	logic                               step_n;
	logic [fdc_timing_pkg::INDEX_W-1:0] index_count;
	logic [7:0]                         index_lo;
	logic                               new_meas;

	//////////////////////////////
	// Host side

	host_regs u_host_regs (
		.CLK_MASTER  (CLK_MASTER),
		.rst         (rst),
		.mcu         (mcu),
		.fd_in       (fd_in),
		.stepping    (stepping),
		.track0_hit  (track0_hit),
		.index_count (index_count),
		.index_lo    (index_lo),
		.new_meas    (new_meas),
		.pmd_out     (pmd_out),
		.drive_ctrl  (drive_ctrl),
		.step_rate   (step_rate),
		.step_cmd    (step_cmd),
		.step_cmd_wr (step_cmd_wr),
		.index_hi_rd (index_hi_rd)
	);

	//////////////////////////////
	// Drive side

	index_timer u_index_timer (
		.CLK_MASTER  (CLK_MASTER),
		.rst         (rst),
		.index       (fd_in.index),
		.index_hi_rd (index_hi_rd),
		.index_count (index_count),
		.index_lo    (index_lo),
		.new_meas    (new_meas)
	);

	step_controller u_step_controller (
		.CLK_MASTER  (CLK_MASTER),
		.rst         (rst),
		.step_rate   (step_rate),
		.step_cmd    (step_cmd),
		.step_cmd_wr (step_cmd_wr),
		.track0      (fd_in.track0),
		.stepping    (stepping),
		.track0_hit  (track0_hit),
		.dir         (dir),
		.step_n      (step_n)
	);

	// Drive lines are active low, register bits active high
	assign fd_out.density = ~drive_ctrl.density;
	assign fd_out.in_use  = ~drive_ctrl.in_use;
	assign fd_out.drv_sel = ~drive_ctrl.drv_sel;
	assign fd_out.motor   = ~drive_ctrl.motor;
	assign fd_out.side    = ~drive_ctrl.side;
	assign fd_out.dir     = dir;
	assign fd_out.step_n  = step_n;

endmodule

// ==== verilog/step_controller.sv ====
`timescale 1ns/1ns

module step_controller (
	input  logic                    CLK_MASTER,
	input  logic                    rst,
	input  logic [7:0]              step_rate,
	input  fdc_regs_pkg::step_cmd_t step_cmd,
	input  logic                    step_cmd_wr,
	input  logic                    track0,
	output logic                    stepping,
	output logic                    track0_hit,
	output logic                    dir,
	output logic                    step_n
);

	fdc_timing_pkg::step_state_e state;
	fdc_timing_pkg::step_div_t   tick_div;	// Clocks within a step tick
	logic                        step_tick;
	logic [7:0]                  phase_cnt;	// Ticks within a phase
	logic                        phase_end;
	logic [6:0]                  steps_left;

	//////////////////////////////
	// Step rate divider

	// Divider held in idle so the first phase is full length
	always_ff @(posedge CLK_MASTER) begin
		if (rst || state == fdc_timing_pkg::ST_IDLE)
			tick_div <= '0;
		else if (step_tick)
			tick_div <= '0;
		else
			tick_div <= tick_div + 1'b1;
	end

	assign step_tick = (tick_div == fdc_timing_pkg::step_div_t'(fdc_timing_pkg::STEP_TICK_CYCLES - 1));

	// Phase is step_rate+1 ticks
	assign phase_end = step_tick && (phase_cnt == step_rate);

	always_ff @(posedge CLK_MASTER) begin
		if (rst || state == fdc_timing_pkg::ST_IDLE || phase_end)
			phase_cnt <= 8'h00;
		else if (step_tick)
			phase_cnt <= phase_cnt + 8'h01;
	end

	//////////////////////////////
	// Seek FSM

	always_ff @(posedge CLK_MASTER) begin
		if (rst) begin
			state      <= fdc_timing_pkg::ST_IDLE;
			steps_left <= 7'd0;
			dir        <= 1'b0;
			track0_hit <= 1'b0;
		end else begin
			case (state)
				fdc_timing_pkg::ST_IDLE: begin
					if (step_cmd_wr && step_cmd.count != 7'd0) begin
						dir        <= step_cmd.dir;
						steps_left <= step_cmd.count;
						if (!step_cmd.dir && track0)
							track0_hit <= 1'b1;	// Already home, no pulse at all
						else begin
							track0_hit <= 1'b0;	// New seek clears old stop
							state      <= fdc_timing_pkg::ST_LOW;
						end
					end
				end
				fdc_timing_pkg::ST_LOW: begin
					if (phase_end) begin
						steps_left <= steps_left - 7'd1;
						state      <= fdc_timing_pkg::ST_HIGH;
					end
				end
				fdc_timing_pkg::ST_HIGH: begin
					if (phase_end) begin
						if (steps_left == 7'd0)
							state <= fdc_timing_pkg::ST_IDLE;	// All steps issued
						else if (!dir && track0) begin
							// Head home, drop the rest
							track0_hit <= 1'b1;
							state      <= fdc_timing_pkg::ST_IDLE;
						end else
							state <= fdc_timing_pkg::ST_LOW;
					end
				end
				default: state <= fdc_timing_pkg::ST_IDLE;
			endcase
		end
	end

	assign stepping = (state != fdc_timing_pkg::ST_IDLE);
	assign step_n   = (state != fdc_timing_pkg::ST_LOW);	// Low half of each step

endmodule

// ==== verilog/index_timer.sv ====
`timescale 1ns/1ns

module index_timer (
	input  logic                               CLK_MASTER,
	input  logic                               rst,
	input  logic                               index,
	input  logic                               index_hi_rd,
	output logic [fdc_timing_pkg::INDEX_W-1:0] index_count,
	output logic [7:0]                         index_lo,
	output logic                               new_meas
);

	logic [2:0]                         idx_sync;	// Two sync flops, then edge history
	logic                               idx_rise;
	fdc_timing_pkg::index_div_t         div_cnt;	// Cycles within a tick
	logic [fdc_timing_pkg::INDEX_W-1:0] tick_cnt;	// Ticks since last edge

	//////////////////////////////
	// Sync and edge detect

	always_ff @(posedge CLK_MASTER) begin
		if (rst)
			idx_sync <= 3'b000;
		else
			idx_sync <= {idx_sync[1:0], index};
	end

	assign idx_rise = idx_sync[1] && !idx_sync[2];

	//////////////////////////////
	// Tick counter

	always_ff @(posedge CLK_MASTER) begin
		if (rst) begin
			div_cnt  <= '0;
			tick_cnt <= '0;
		end else if (idx_rise) begin
			// Edge cycle counts as the first of the new period
			div_cnt  <= fdc_timing_pkg::index_div_t'(1);
			tick_cnt <= '0;
		end else if (div_cnt == fdc_timing_pkg::index_div_t'(fdc_timing_pkg::INDEX_TICK_CYCLES - 1)) begin
			div_cnt <= '0;
			if (tick_cnt != '1)
				tick_cnt <= tick_cnt + 1'b1;	// Saturate on a stopped drive
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// Measurement latches
	always_ff @(posedge CLK_MASTER) begin
		if (idx_rise)
			index_count <= tick_cnt;
		if (index_hi_rd)
			index_lo <= index_count[7:0];	// Keeps hi/lo pair coherent
	end

	always_ff @(posedge CLK_MASTER) begin
		if (rst)
			new_meas <= 1'b0;
		else if (index_hi_rd)
			new_meas <= 1'b0;	// Read wins over a fresh edge
		else if (idx_rise)
			new_meas <= 1'b1;
	end

endmodule

// ==== verilog/host_regs.sv ====
`timescale 1ns/1ns

module host_regs (
	input  logic                                 CLK_MASTER,
	input  logic                                 rst,
	input  fdc_regs_pkg::mcu_bus_t               mcu,
	input  fdc_timing_pkg::fd_in_t               fd_in,
	input  logic                                 stepping,
	input  logic                                 track0_hit,
	input  logic [fdc_timing_pkg::INDEX_W-1:0]   index_count,
	input  logic [7:0]                           index_lo,
	input  logic                                 new_meas,
	output logic [7:0]                           pmd_out,
	output fdc_regs_pkg::drive_ctrl_t            drive_ctrl,
	output logic [7:0]                           step_rate,
	output fdc_regs_pkg::step_cmd_t              step_cmd,
	output logic                                 step_cmd_wr,
	output logic                                 index_hi_rd
);

	logic [7:0] addr;	// Latched register address
	logic [7:0] scratch;
	logic       rd_q;	// Read level, one cycle late
	logic [7:0] status1;
	logic [7:0] status2;

	//////////////////////////////
	// Address latch

	always_ff @(posedge CLK_MASTER) begin
		if (rst) begin
			addr <= 8'h00;
			rd_q <= 1'b0;
		end else begin
			if (mcu.ale)
				addr <= mcu.data;	// Address taken from data byte
			rd_q <= mcu.rd;
		end
	end

	//////////////////////////////
	// Write decode

	always_ff @(posedge CLK_MASTER) begin
		if (rst) begin
			drive_ctrl  <= '0;	// All drive lines inactive
			step_rate   <= 8'h00;
			step_cmd    <= '0;
			step_cmd_wr <= 1'b0;
		end else begin
			step_cmd_wr <= 1'b0;
			if (mcu.wr) begin
				case (addr)
					fdc_regs_pkg::REG_DRIVE_CTRL: drive_ctrl <= fdc_regs_pkg::drive_ctrl_t'(mcu.data);
					fdc_regs_pkg::REG_STEP_RATE:  step_rate <= mcu.data;
					fdc_regs_pkg::REG_STEP_CMD: begin
						step_cmd    <= fdc_regs_pkg::step_cmd_t'(mcu.data);
						step_cmd_wr <= 1'b1;	// Lines up with the new command byte
					end
					default: ;
				endcase
			end
		end
	end

	// Scratchpad, bus test only
	always_ff @(posedge CLK_MASTER) begin
		if (mcu.wr && addr == fdc_regs_pkg::REG_SCRATCH)
			scratch <= mcu.data;
	end

	// First cycle of a high byte read freezes the low byte in index_timer
	assign index_hi_rd = mcu.rd && !rd_q && (addr == fdc_regs_pkg::REG_INDEX_HI);

	//////////////////////////////
	// Readback

	// Seek stop and new index reading
	assign status1 = {3'b000, track0_hit, new_meas, 3'b000};

	// Drive lines as they arrive, plus busy
	assign status2 = {fd_in.index, fd_in.track0, fd_in.wrprot, fd_in.rdy_dchg,
		fd_in.density, stepping, 2'b00};

	always_comb begin
		pmd_out = 8'h00;	// Idle bus reads zero
		if (mcu.rd) begin
			case (addr)
				fdc_regs_pkg::REG_ID_TYPE_L:   pmd_out = fdc_regs_pkg::MCO_TYPE[7:0];
				fdc_regs_pkg::REG_ID_TYPE_H:   pmd_out = fdc_regs_pkg::MCO_TYPE[15:8];
				fdc_regs_pkg::REG_ID_VER_L:    pmd_out = fdc_regs_pkg::MCO_VERSION[7:0];
				fdc_regs_pkg::REG_ID_VER_H:    pmd_out = fdc_regs_pkg::MCO_VERSION[15:8];
				fdc_regs_pkg::REG_STATUS1:     pmd_out = status1;
				fdc_regs_pkg::REG_STATUS2:     pmd_out = status2;
				fdc_regs_pkg::REG_SCRATCH:     pmd_out = scratch;
				fdc_regs_pkg::REG_SCRATCH_INV: pmd_out = ~scratch;
				fdc_regs_pkg::REG_FIXED_55:    pmd_out = 8'h55;
				fdc_regs_pkg::REG_FIXED_AA:    pmd_out = 8'hAA;
				fdc_regs_pkg::REG_INDEX_HI:    pmd_out = index_count[15:8];	// Live latch
				fdc_regs_pkg::REG_INDEX_LO:    pmd_out = index_lo;	// Frozen copy
				default:                       pmd_out = 8'h00;
			endcase
		end
	end

endmodule

// ==== verilog/fdc_timing_pkg.sv ====
package fdc_timing_pkg;

	//////////////////////////////
	// Tick lengths and widths

	localparam int INDEX_TICK_CYCLES = 100;	// Clocks per index tick
	localparam int STEP_TICK_CYCLES  = 20;	// Clocks per step tick
	localparam int INDEX_W           = 16;	// Index count width

	localparam int INDEX_DIV_W = $clog2(INDEX_TICK_CYCLES);
	localparam int STEP_DIV_W  = $clog2(STEP_TICK_CYCLES);

	typedef logic [INDEX_DIV_W-1:0] index_div_t;	// Prescaler for index ticks
	typedef logic [STEP_DIV_W-1:0]  step_div_t;	// Prescaler for step ticks

	// Stepper FSM
	typedef enum logic [1:0] {
		ST_IDLE,	// Not stepping
		ST_LOW,	// Step pulse asserted
		ST_HIGH	// Recovery half of the step
	} step_state_e;

	//////////////////////////////
	// Drive side structs

	// Lines coming back from the drive
	typedef struct packed {
		logic index;
		logic track0;	// High at track 0
		logic wrprot;
		logic rdy_dchg;	// Ready / disk changed
		logic density;
	} fd_in_t;

	// Lines going out to the drive
	typedef struct packed {
		logic       density;	// Active low
		logic       in_use;	// Active low
		logic [3:0] drv_sel;	// Active low
		logic       motor;	// Active low
		logic       side;	// Active low
		logic       dir;
		logic       step_n;
	} fd_out_t;

endpackage

// ==== verilog/fdc_regs_pkg.sv ====
package fdc_regs_pkg;

	//////////////////////////////
	// Register map

	// Host register addresses, all on the low address byte
	typedef enum logic [7:0] {
		REG_ID_TYPE_L   = 8'h04,	// Type low byte (read side of 04)
		REG_ID_TYPE_H   = 8'h05,
		REG_ID_VER_L    = 8'h06,
		REG_ID_VER_H    = 8'h07,
		REG_STATUS1     = 8'h0E,	// Seek and index flags
		REG_STATUS2     = 8'h0F,	// Raw drive lines plus busy
		REG_SCRATCH     = 8'h30,
		REG_SCRATCH_INV = 8'h31,
		REG_FIXED_55    = 8'h32,
		REG_FIXED_AA    = 8'h33,
		REG_INDEX_HI    = 8'h40,	// Reading this one freezes the low byte
		REG_INDEX_LO    = 8'h41,
		REG_STEP_RATE   = 8'hF0,
		REG_STEP_CMD    = 8'hFF
	} reg_addr_e;

	// 04 doubles as the drive control write register
	localparam reg_addr_e REG_DRIVE_CTRL = REG_ID_TYPE_L;

	//////////////////////////////
	// Identity

	localparam logic [15:0] MCO_TYPE    = 16'hDD55;	// Microcode type
	localparam logic [15:0] MCO_VERSION = 16'h002D;	// Microcode version

	//////////////////////////////
	// Host side structs

	// Byte-wide register bus from the microcontroller
	typedef struct packed {
		logic [7:0] data;	// Address or write data
		logic       ale;	// Address load strobe
		logic       rd;	// Read level
		logic       wr;	// Write strobe
	} mcu_bus_t;

	// Drive control register, one bit per active-low drive line
	typedef struct packed {
		logic       side;	// Bit 7
		logic       motor;	// Bit 6
		logic [3:0] drv_sel;	// Bits 5..2
		logic       in_use;	// Bit 1
		logic       density;	// Bit 0
	} drive_ctrl_t;

	// Step command byte
	typedef struct packed {
		logic       dir;	// 1 = away from track 0
		logic [6:0] count;	// Number of steps
	} step_cmd_t;

endpackage
